/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
RTL_TOP   ?= cpu_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb.f */
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/program_counter.sv
verilog/register_file.sv
verilog/alu.sv
verilog/run_sequencer.sv
verilog/host_interface.sv
verilog/cpu_top.sv
tests/tb_cpu_top.sv

/* tests/tb_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top
        import cpu_pkg::*;
;

        localparam int DATA_W      = 16;
        localparam int PROG_DEPTH  = 256;
        localparam int POLL_LIMIT  = 200;               // STATUS reads before giving up
        localparam int READY_LIMIT = 16;                // Access cycles before giving up

        logic        clk = 1'b0;
        logic        rst_n;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;

        instr_t            prog_model [PROG_DEPTH];     // Expected program memory
        logic [DATA_W-1:0] reg_model [16];              // Expected registers
        logic              z_model;
        instr_t            prog_q [$];                  // Program under construction
        int                err_count  = 0;
        int                test_base  = 0;              // Errors before the current test
        int                pass_count = 0;
        int                fail_count = 0;

        cpu_top #(.DATA_W(DATA_W), .PROG_DEPTH(PROG_DEPTH)) cpu_top_i (
                .clk(clk), .rst_n(rst_n),
                .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
                .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr));

        always #5 clk = ~clk;                           // 10 ns period

        task automatic end_on_timeout(input string what);
                $display("Timeout while waiting for %s", what);
                $display("TEST RESULT: FAIL");
                $finish;
        endtask

        task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
                if (act !== exp)
                begin
                        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
                        err_count++;
                end
        endtask

        task automatic check_instr(input string name, input instr_t exp, input instr_t act);
                if (act !== exp)
                begin
                        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
                        err_count++;
                end
        endtask

        task automatic check_state(input string name, input run_state_t exp,
                                   input run_state_t act);
                if (act !== exp)
                begin
                        $display("Fail at %0t: %s expected %s, got %s", $time, name,
                                 exp.name(), act.name());
                        err_count++;
                end
        endtask

        task automatic check_err(input string name, input logic exp, input logic act);
                if (act !== exp)
                begin
                        $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
                        err_count++;
                end
        endtask

        task automatic finish_test(input string name);
                if (err_count == test_base)
                begin
                        pass_count++;
                        $display("Test %s: passed", name);
                end
                else
                begin
                        fail_count++;
                        $display("Test %s: failed with %0d errors", name, err_count - test_base);
                end
                test_base = err_count;
        endtask

        // Setup phase, then access phase held until pready
        task automatic apb_access(input logic wr, input logic [11:0] addr,
                                  input logic [31:0] wdata, output logic [31:0] rdata,
                                  output logic err);
                int n;
                n = 0;
                @(posedge clk);
                psel    <= 1'b1;
                penable <= 1'b0;
                pwrite  <= wr;
                paddr   <= addr;
                pwdata  <= wdata;
                @(posedge clk);
                penable <= 1'b1;
                @(negedge clk);                         // Sample mid-cycle
                while (pready !== 1'b1)
                begin
                        n++;
                        if (n > READY_LIMIT)
                                end_on_timeout("pready");
                        @(negedge clk);
                end
                rdata = prdata;
                err   = pslverr;
                @(posedge clk);                         // Access completes here
                psel    <= 1'b0;
                penable <= 1'b0;
        endtask

        task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                                 output logic err);
                logic [31:0] unused_rdata;
                apb_access(1'b1, addr, data, unused_rdata, err);
        endtask

        task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                                output logic err);
                apb_access(1'b0, addr, 32'h0, data, err);
        endtask

        function automatic logic [DATA_W-1:0] alu_model(input int op,
                                                        input logic [DATA_W-1:0] a,
                                                        input logic [DATA_W-1:0] b);
                case (op)
                        0:       return a;
                        1:       return ~a;
                        2:       return a + b;
                        3:       return a - b;
                        4:       return a & b;
                        5:       return a | b;
                        6:       return -a;
                        default: return -b;
                endcase
        endfunction

        // Executes prog_model from word 0 until a halt word
        task automatic run_model();
                instr_t            w;
                int                pc;
                int                op;
                int                steps;
                logic [DATA_W-1:0] a;
                logic [DATA_W-1:0] r;
                logic              done;
                pc      = 0;
                steps   = 0;
                done    = 1'b0;
                z_model = 1'b0;                         // Flag cleared by start
                while (!done && steps < 4 * PROG_DEPTH)
                begin
                        w = prog_model[pc];
                        steps++;
                        a = DATA_W'(w.operand.alu.imm);
                        if (w.opcode[5])
                        begin
                                op = int'(w.opcode[4:2]);
                                a  = reg_model[w.operand.alu.ra];
                        end
                        else
                        begin
                                case (w.opcode[5:2])
                                        4'b0000: op = 0;
                                        4'b0010: op = 2;
                                        4'b0011: op = 3;
                                        4'b0100: op = 4;
                                        4'b0101: op = 5;
                                        4'b0110: op = 1;        // Not of immediate
                                        4'b0111: op = 6;        // Negated immediate
                                        default: op = -1;       // Jumps and halt
                                endcase
                        end
                        if (op >= 0)
                        begin
                                r = alu_model(op, a, reg_model[w.operand.alu.rb]);
                                reg_model[w.operand.alu.rd] = r;
                                z_model = (r == '0);
                                pc = (pc + 1) % PROG_DEPTH;
                        end
                        else if (w.opcode == OP_J || (w.opcode == OP_JZ && z_model)
                                 || (w.opcode == OP_JNZ && !z_model))
                                pc = int'(w.operand.jump.target) % PROG_DEPTH;
                        else if (w.opcode == OP_JZ || w.opcode == OP_JNZ)
                                pc = (pc + 1) % PROG_DEPTH;     // Not taken
                        else
                                done = 1'b1;
                end
        endtask

        // Random ALU words, optional forward jumps, halt at the end
        task automatic build_program(input int len, input bit jumps);
                instr_t w;
                int     t;
                prog_q.delete();
                for (int i = 0; i < len - 1; i++)
                begin
                        w = instr_t'($urandom);
                        if ($urandom_range(0, 2) == 0)
                                w.operand.alu.imm = '0;         // More zero results
                        if ($urandom_range(0, 1) == 0)
                                w.opcode = {1'b1, 5'($urandom)};
                        else
                        begin
                                t = $urandom_range(0, 6);
                                w.opcode = {(t == 0) ? 4'b0000 : 4'(t + 1), 2'($urandom)};
                        end
                        if (jumps && $urandom_range(0, 3) == 0)
                        begin
                                w.opcode = OP_J + 6'($urandom_range(0, 2));
                                t = i + $urandom_range(2, 4);
                                w.operand.jump.target = 10'((t > len - 1) ? len - 1 : t);
                        end
                        prog_q.push_back(w);
                end
                w = instr_t'($urandom);
                w.opcode = OP_HALT;
                prog_q.push_back(w);
        endtask

        task automatic load_program();
                logic e;
                foreach (prog_q[i])
                begin
                        apb_write(12'(i * 4), prog_q[i], e);
                        check_err("pslverr", 1'b0, e);
                        prog_model[i] = prog_q[i];
                end
        endtask

        task automatic check_regs();
                logic [31:0] d;
                logic        e;
                for (int n = 0; n < 16; n++)
                begin
                        apb_read(REG_BASE + 12'(4 * n), d, e);
                        check_err("pslverr", 1'b0, e);
                        check_word($sformatf("r%0d", n), reg_model[n], d[DATA_W-1:0]);
                end
        endtask

        task automatic wait_halted();
                logic [31:0] d;
                logic        e;
                int          n;
                n = 0;
                apb_read(ADDR_STATUS, d, e);
                while (run_state_t'(d[1:0]) != st_halted)
                begin
                        n++;
                        if (n > POLL_LIMIT)
                                end_on_timeout("st_halted");
                        apb_read(ADDR_STATUS, d, e);
                end
        endtask

        task automatic start_and_check();
                logic e;
                apb_write(ADDR_CTRL, 32'h1, e);
                check_err("pslverr", 1'b0, e);
                wait_halted();
                run_model();
                check_regs();
        endtask

        initial
        begin
                logic [31:0] d;
                logic        e;
                instr_t      w;
                int          idx_q [$];
                psel    <= 1'b0;
                penable <= 1'b0;
                pwrite  <= 1'b0;
                paddr   <= '0;
                pwdata  <= '0;
                rst_n   <= 1'b0;
                void'($urandom(68));
                for (int i = 0; i < PROG_DEPTH; i++)
                        prog_model[i] = '0;
                for (int i = 0; i < 16; i++)
                        reg_model[i] = '0;
                repeat (4) @(posedge clk);
                rst_n <= 1'b1;

                apb_read(ADDR_STATUS, d, e);
                check_err("pslverr", 1'b0, e);
                check_state("status", st_idle, run_state_t'(d[1:0]));
                check_regs();
                finish_test("reset");

                // High words stay out of reach of the short programs
                for (int k = 0; k < 8; k++)
                begin
                        idx_q.push_back($urandom_range(128, PROG_DEPTH - 1));
                        w = instr_t'($urandom);
                        apb_write(12'(idx_q[k] * 4), w, e);
                        check_err("pslverr", 1'b0, e);
                        prog_model[idx_q[k]] = w;
                end
                foreach (idx_q[k])
                begin
                        apb_read(12'(idx_q[k] * 4), d, e);
                        check_instr($sformatf("prog[%0d]", idx_q[k]), prog_model[idx_q[k]],
                                    instr_t'(d));
                end
                finish_test("program_readback");

                repeat (4)
                begin
                        build_program(20, 1'b0);
                        load_program();
                        start_and_check();
                end
                finish_test("random_alu");

                repeat (6)
                begin
                        build_program(24, 1'b1);
                        load_program();
                        start_and_check();
                end
                finish_test("jumps");

                build_program(48, 1'b0);                // Long enough to still be running
                load_program();
                apb_write(ADDR_CTRL, 32'h1, e);
                check_err("pslverr", 1'b0, e);
                apb_read(ADDR_STATUS, d, e);
                check_state("status", st_run, run_state_t'(d[1:0]));
                apb_write(12'h00C, $urandom, e);
                check_err("pslverr", 1'b1, e);
                apb_write(ADDR_CTRL, 32'h1, e);
                check_err("pslverr", 1'b1, e);
                apb_read(12'hA00, d, e);
                check_err("pslverr", 1'b1, e);
                check_word("prdata", '0, d[DATA_W-1:0]);
                apb_write(12'h900, $urandom, e);
                check_err("pslverr", 1'b1, e);
                wait_halted();
                run_model();
                check_regs();
                apb_read(12'h00C, d, e);
                check_instr("prog[3]", prog_model[3], instr_t'(d));
                finish_test("error_response");

                $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
                if (fail_count == 0)
                        $display("TEST RESULT: PASS");
                else
                        $display("TEST RESULT: FAIL");
                $finish;
        end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
        import cpu_pkg::*;
#(
        parameter int DATA_W = 16
)
(
        input  alu_op_t           op,
        input  logic [DATA_W-1:0] a,
        input  logic [DATA_W-1:0] b,
        output logic [DATA_W-1:0] result,
        output logic              zero
);

        always_comb
        begin
                case (op)
                        ALU_A:     result = a;
                        ALU_NOT_A: result = ~a;
                        ALU_ADD:   result = a + b;      // Carry dropped
                        ALU_SUB:   result = a - b;
                        ALU_AND:   result = a & b;
                        ALU_OR:    result = a | b;
                        ALU_NEG_A: result = -a;         // Two's complement
                        ALU_NEG_B: result = -b;
                        default:   result = a;
                endcase
        end

        assign zero = (result == '0);

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit
        import cpu_pkg::*;
(
        input  opcode_t opcode,
        input  logic    z,
        output ctrl_t   ctrl
);

        // Most specific patterns first so jumps win over the immediate group
        always_comb
        begin
                ctrl        = '0;
                ctrl.pc_inc = 1'b1;                     // Sequential unless told otherwise
                casez (opcode)
                        OP_J:
                        begin
                                ctrl.pc_inc = 1'b0;
                        end
                        OP_JZ:
                        begin
                                ctrl.pc_inc = ~z;       // Load target when z set
                        end
                        OP_JNZ:
                        begin
                                ctrl.pc_inc = z;        // Load target when z clear
                        end
                        6'b1?????:                      // Register group, op in bits 4..2
                        begin
                                ctrl.alu_op = alu_op_t'(opcode[4:2]);
                                ctrl.reg_we = 1'b1;
                                ctrl.z_we   = 1'b1;
                        end
                        6'b0000??,
                        6'b001???,
                        6'b010???:                      // Immediate a, add, sub, and, or
                        begin
                                ctrl.alu_op  = alu_op_t'(opcode[4:2]);
                                ctrl.imm_sel = 1'b1;
                                ctrl.reg_we  = 1'b1;
                                ctrl.z_we    = 1'b1;
                        end
                        6'b0110??:                      // Not of immediate
                        begin
                                ctrl.alu_op  = ALU_NOT_A;
                                ctrl.imm_sel = 1'b1;
                                ctrl.reg_we  = 1'b1;
                                ctrl.z_we    = 1'b1;
                        end
                        6'b0111??:                      // Negated immediate
                        begin
                                ctrl.alu_op  = ALU_NEG_A;
                                ctrl.imm_sel = 1'b1;
                                ctrl.reg_we  = 1'b1;
                                ctrl.z_we    = 1'b1;
                        end
                        default:                        // 0001 11 and anything unlisted
                        begin
                                ctrl.pc_inc = 1'b0;
                                ctrl.halt   = 1'b1;
                        end
                endcase
        end

endmodule

`default_nettype wire

/* verilog/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

        typedef logic [5:0] opcode_t;                   // Top six bits of a word

        localparam opcode_t OP_J    = 6'b000100;        // Unconditional jump
        localparam opcode_t OP_JZ   = 6'b000101;        // Jump when z set
        localparam opcode_t OP_JNZ  = 6'b000110;        // Jump when z clear
        localparam opcode_t OP_HALT = 6'b000111;        // Any undecoded opcode halts too

        typedef struct packed {
                logic [13:0] imm;                       // Zero-extended when used
                logic [3:0]  ra;
                logic [3:0]  rb;
                logic [3:0]  rd;                        // Destination
        } alu_fields_t;

        typedef struct packed {
                logic [9:0]  target;                    // Absolute word index
                logic [15:0] unused;
        } jump_fields_t;

        typedef union packed {
                alu_fields_t  alu;                      // ALU view of the operand
                jump_fields_t jump;                     // Jump view of the operand
        } operand_u;

        typedef struct packed {
                opcode_t  opcode;
                operand_u operand;
        } instr_t;                                      // 32-bit instruction word

        // Encoding follows the low three opcode bits of the register group
        typedef enum logic [2:0] {
                ALU_A     = 3'b000,
                ALU_NOT_A = 3'b001,
                ALU_ADD   = 3'b010,
                ALU_SUB   = 3'b011,
                ALU_AND   = 3'b100,
                ALU_OR    = 3'b101,
                ALU_NEG_A = 3'b110,
                ALU_NEG_B = 3'b111
        } alu_op_t;

        typedef struct packed {
                logic    pc_inc;                        // Increment, else load target
                logic    imm_sel;                       // Immediate as operand a
                logic    reg_we;
                logic    z_we;
                alu_op_t alu_op;
                logic    halt;
        } ctrl_t;

        typedef enum logic [1:0] {
                st_idle   = 2'd0,
                st_run    = 2'd1,
                st_halted = 2'd2
        } run_state_t;

        localparam logic [11:0] ADDR_CTRL   = 12'h800;  // Bit 0 starts the core
        localparam logic [11:0] ADDR_STATUS = 12'h804;  // Run state, read only
        localparam logic [11:0] REG_BASE    = 12'hC00;  // Sixteen words, read only

endpackage

`default_nettype wire

/* verilog/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top
        import cpu_pkg::*;
#(
        parameter int  DATA_W     = 16,
        parameter int  PROG_DEPTH = 256,
        localparam int PC_W       = $clog2(PROG_DEPTH)
)
(
        input  logic        clk,
        input  logic        rst_n,
        input  logic        psel,
        input  logic        penable,
        input  logic        pwrite,
        input  logic [11:0] paddr,
        input  logic [31:0] pwdata,
        output logic [31:0] prdata,
        output logic        pready,
        output logic        pslverr
);

        instr_t            instr;
        ctrl_t             ctrl;
        run_state_t        state;
        logic [PC_W-1:0]   pc;
        logic              start;
        logic              running;
        logic              clear;
        logic              z;
        logic [3:0]        host_addr;
        logic [DATA_W-1:0] host_data;
        logic [DATA_W-1:0] ra_data;
        logic [DATA_W-1:0] rb_data;
        logic [DATA_W-1:0] alu_a;
        logic [DATA_W-1:0] alu_result;
        logic              alu_zero;
        logic              rf_we;

        // Operand a is the immediate or register ra
        assign alu_a = ctrl.imm_sel ? DATA_W'(instr.operand.alu.imm) : ra_data;
        assign rf_we = running && ctrl.reg_we;         // Writes only while running

        host_interface #(.DATA_W(DATA_W), .PROG_DEPTH(PROG_DEPTH)) host_interface_i (
                .clk(clk), .rst_n(rst_n),
                .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
                .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
                .pc(pc), .instr(instr), .start(start), .state(state),
                .host_addr(host_addr), .host_data(host_data));

        run_sequencer run_sequencer_i (
                .clk(clk), .rst_n(rst_n), .start(start), .halt(ctrl.halt),
                .z_we(ctrl.z_we), .alu_zero(alu_zero), .state(state),
                .running(running), .clear(clear), .z(z));

        control_unit control_unit_i (.opcode(instr.opcode), .z(z), .ctrl(ctrl));

        program_counter #(.PROG_DEPTH(PROG_DEPTH)) program_counter_i (
                .clk(clk), .rst_n(rst_n), .clear(clear), .step(running),
                .load(!ctrl.pc_inc), .target(instr.operand.jump.target), .pc(pc));

        register_file #(.DATA_W(DATA_W)) register_file_i (
                .clk(clk), .rst_n(rst_n), .we(rf_we),
                .waddr(instr.operand.alu.rd), .wdata(alu_result),
                .ra_addr(instr.operand.alu.ra), .rb_addr(instr.operand.alu.rb),
                .ra_data(ra_data), .rb_data(rb_data),
                .host_addr(host_addr), .host_data(host_data));

        alu #(.DATA_W(DATA_W)) alu_i (
                .op(ctrl.alu_op), .a(alu_a), .b(rb_data),
                .result(alu_result), .zero(alu_zero));

endmodule

`default_nettype wire

/* verilog/host_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module host_interface
        import cpu_pkg::*;
#(
        parameter int  DATA_W     = 16,
        parameter int  PROG_DEPTH = 256,
        localparam int PC_W       = $clog2(PROG_DEPTH)
)
(
        input  logic              clk,
        input  logic              rst_n,
        input  logic              psel,
        input  logic              penable,
        input  logic              pwrite,
        input  logic [11:0]       paddr,
        input  logic [31:0]       pwdata,
        output logic [31:0]       prdata,
        output logic              pready,
        output logic              pslverr,
        input  logic [PC_W-1:0]   pc,
        output instr_t            instr,
        output logic              start,
        input  run_state_t        state,
        output logic [3:0]        host_addr,
        input  logic [DATA_W-1:0] host_data
);

        instr_t     mem [PROG_DEPTH];                   // Program memory
        logic [8:0] widx;                               // Word index in program space
        logic       access;
        logic       busy;
        logic       prog_hit;
        logic       ctrl_hit;
        logic       status_hit;
        logic       reg_hit;
        logic       mapped;
        logic       go;                                 // CTRL write asking for a start
        logic       prog_we;

        assign access     = psel && penable;            // APB access phase
        assign busy       = (state == st_run);
        assign widx       = paddr[10:2];
        assign prog_hit   = !paddr[11] && (widx < PROG_DEPTH) && (paddr[1:0] == 2'b00);
        assign ctrl_hit   = (paddr == ADDR_CTRL);
        assign status_hit = (paddr == ADDR_STATUS);
        assign reg_hit    = (paddr[11:6] == REG_BASE[11:6]) && (paddr[1:0] == 2'b00);
        assign mapped     = prog_hit || ctrl_hit || status_hit || reg_hit;
        assign go         = access && pwrite && ctrl_hit && pwdata[0];

        assign start   = go && !busy;                   // Dropped while running
        assign prog_we = access && pwrite && prog_hit && !busy;
        assign pready  = 1'b1;                          // No wait states

        // Busy writes, stray addresses and writes to read-only words
        assign pslverr = access && (!mapped
                        || (pwrite && prog_hit && busy)
                        || (go && busy)
                        || (pwrite && (status_hit || reg_hit)));

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        for (int i = 0; i < PROG_DEPTH; i++)
                                mem[i] <= '0;           // Zero word is R0 = 0
                end
                else if (prog_we)
                begin
                        mem[widx[PC_W-1:0]] <= instr_t'(pwdata);
                end
        end

        assign instr     = mem[pc];                     // Fetch for the core
        assign host_addr = paddr[5:2];

        always_comb
        begin
                prdata = '0;                            // CTRL and unmapped read as zero
                if (prog_hit)
                        prdata = mem[widx[PC_W-1:0]];
                else if (status_hit)
                        prdata = 32'(state);
                else if (reg_hit)
                        prdata = 32'(host_data);
        end

        a_penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n)
                penable |-> psel && $past(psel));

endmodule

`default_nettype wire

/* verilog/program_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module program_counter
#(
        parameter int  PROG_DEPTH = 256,
        localparam int PC_W       = $clog2(PROG_DEPTH)
)
(
        input  logic            clk,
        input  logic            rst_n,
        input  logic            clear,                  // Start of a run
        input  logic            step,                   // One instruction retires
        input  logic            load,                   // Take the jump target
        input  logic [9:0]      target,
        output logic [PC_W-1:0] pc
);

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        pc <= '0;
                else if (clear)
                        pc <= '0;                       // Wins over a retiring instruction
                else if (step)
                begin
                        if (load)
                                pc <= target[PC_W-1:0];
                        else if (pc == PC_W'(PROG_DEPTH - 1))
                                pc <= '0;               // Wrap at end of memory
                        else
                                pc <= pc + 1'b1;
                end
        end

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
#(
        parameter int DATA_W = 16
)
(
        input  logic              clk,
        input  logic              rst_n,
        input  logic              we,
        input  logic [3:0]        waddr,
        input  logic [DATA_W-1:0] wdata,
        input  logic [3:0]        ra_addr,
        input  logic [3:0]        rb_addr,
        output logic [DATA_W-1:0] ra_data,
        output logic [DATA_W-1:0] rb_data,
        input  logic [3:0]        host_addr,            // APB readback port
        output logic [DATA_W-1:0] host_data
);

        logic [DATA_W-1:0] regs [16];

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                begin
                        for (int i = 0; i < 16; i++)
                                regs[i] <= '0;
                end
                else if (we)
                begin
                        regs[waddr] <= wdata;           // R0 is an ordinary register
                end
        end

        assign ra_data   = regs[ra_addr];               // Asynchronous reads
        assign rb_data   = regs[rb_addr];
        assign host_data = regs[host_addr];

endmodule

`default_nettype wire

/* verilog/run_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module run_sequencer
        import cpu_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       start,                       // One-cycle pulse from the host
        input  logic       halt,
        input  logic       z_we,
        input  logic       alu_zero,
        output run_state_t state,
        output logic       running,                     // Current instruction commits
        output logic       clear,
        output logic       z
);

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        state <= st_idle;
                else
                begin
                        case (state)
                                st_run:
                                        if (halt)
                                                state <= st_halted;
                                default:        // Idle or halted, waiting for start
                                        if (start)
                                                state <= st_run;
                        endcase
                end
        end

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        z <= 1'b0;
                else if (start)
                        z <= 1'b0;                      // Fresh flag for each run
                else if (running && z_we)
                        z <= alu_zero;
        end

        assign running = (state == st_run) && !halt;    // Halt word does not retire
        assign clear   = start;

        // Host side filters starts while busy
        a_no_start_in_run: assert property (@(posedge clk) disable iff (!rst_n)
                start |-> state != st_run);

endmodule

`default_nettype wire
